/* Makefile */
VERILATOR ?= verilator
TOP ?= mem_top_tb
RTL_TOP ?= mem_top
FILELIST ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR)

/* compile.f */
source/common_pkg.sv
source/decode_pkg.sv
source/readdata.sv
source/writedata.sv
source/data_ram.sv
source/mem_stage.sv
source/mem_top.sv
testbench/mem_top_tb.sv

/* source/common_pkg.sv */
package common_pkg;

	typedef logic u1;         // flags
	typedef logic [2:0] u3;   // byte offset inside a doubleword
	typedef logic [4:0] u5;   // register index
	typedef logic [7:0] u8;   // byte strobe
	typedef logic [63:0] u64; // data and address

	// request channel, valid/ready
	typedef struct packed {
		u64 addr;   // byte address, RAM drops bits [2:0]
		u64 wdata;  // already replicated into lanes
		u8 strobe;  // one bit per byte lane
		u1 write;
	} dbus_req_t;

	// response channel, one-cycle pulse
	typedef struct packed {
		u64 rdata;  // whole doubleword
	} dbus_resp_t;

endpackage

/* source/data_ram.sv */
`timescale 1ns/1ps

module data_ram #(
	parameter int DEPTH = 256,
	parameter int LATENCY = 2
) (
	input common_pkg::u1 clk,
	input common_pkg::u1 arst_n,
	input common_pkg::u1 dreq_valid,
	output common_pkg::u1 dreq_ready,
	input common_pkg::dbus_req_t dreq,
	output common_pkg::u1 dresp_valid,
	output common_pkg::dbus_resp_t dresp
);
	import common_pkg::*;

	localparam int IW = $clog2(DEPTH);        // depth is a power of two
	localparam int CW = $clog2(LATENCY + 1);

	u64 mem [DEPTH];
	u64 rdata_q;
	u1 pending;
	logic [CW-1:0] cnt;
	logic [IW-1:0] idx;
	u1 req_fire;

	assign idx = dreq.addr[IW+2:3]; // doubleword index, wraps at DEPTH
	assign req_fire = dreq_valid & dreq_ready;
	assign dreq_ready = ~pending;
	assign dresp.rdata = rdata_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			pending <= 1'b0;
			cnt <= '0;
			dresp_valid <= 1'b0;
		end else begin
			dresp_valid <= 1'b0;
			if (req_fire) begin
				pending <= 1'b1;
				cnt <= CW'(LATENCY - 1);
			end else if (pending) begin
				if (cnt == '0) begin
					pending <= 1'b0;
					dresp_valid <= 1'b1; // single pulse per request
				end else begin
					cnt <= cnt - 1'b1;
				end
			end
		end
	end

	// read happens at acceptance, data held until the pulse
	always_ff @(posedge clk) begin
		if (req_fire) begin
			rdata_q <= mem[idx];
			if (dreq.write) begin
				for (int i = 0; i < 8; i++) begin
					if (dreq.strobe[i]) mem[idx][8*i +: 8] <= dreq.wdata[8*i +: 8];
				end
			end
		end
	end

endmodule

/* source/decode_pkg.sv */
package decode_pkg;

	import common_pkg::*;

	typedef enum logic [1:0] {
		MSIZE1, // byte
		MSIZE2, // halfword
		MSIZE4, // word
		MSIZE8  // doubleword
	} msize_t;

	// operation handed over by the upstream stage
	typedef struct packed {
		u64 addr;          // effective address, or ALU result
		u64 wdata;         // store source, low-aligned
		msize_t msize;
		u1 mem_read;
		u1 mem_write;
		u1 mem_unsigned;   // zero-extend on load
		u5 dst;
	} mem_op_t;

	// result handed to writeback
	typedef struct packed {
		u5 dst;
		u64 data;          // load value, ALU value, or zero for stores
		u1 misaligned;
	} mem_result_t;

endpackage

/* source/mem_stage.sv */
`timescale 1ns/1ps

module mem_stage (
	input common_pkg::u1 clk,
	input common_pkg::u1 arst_n,

	input common_pkg::u1 in_valid,
	output common_pkg::u1 in_ready,
	input decode_pkg::mem_op_t in_op,

	output common_pkg::u1 out_valid,
	input common_pkg::u1 out_ready,
	output decode_pkg::mem_result_t out_res,

	output common_pkg::u1 dreq_valid,
	input common_pkg::u1 dreq_ready,
	output common_pkg::dbus_req_t dreq,

	input common_pkg::u1 dresp_valid,
	input common_pkg::dbus_resp_t dresp
);
	import common_pkg::*;
	import decode_pkg::*;

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		WAIT,
		DONE
	} state_t;

	state_t state;
	mem_op_t op_q;
	dbus_req_t req_q;
	mem_result_t res_q;

	u64 wd_data;
	u8 wd_strobe;
	u1 wd_misaligned;
	u64 ld_data;
	u1 is_mem;
	u1 in_fire;

	// store lanes and alignment come from the incoming op
	writedata u_writedata (
		.wdata(in_op.wdata),
		.addr(in_op.addr[2:0]),
		.msize(in_op.msize),
		.data(wd_data),
		.strobe(wd_strobe),
		.misaligned(wd_misaligned)
	);

	// load formatting uses the latched op
	readdata u_readdata (
		._rd(dresp.rdata),
		.rd(ld_data),
		.addr(op_q.addr[2:0]),
		.msize(op_q.msize),
		.mem_unsigned(op_q.mem_unsigned)
	);

	assign is_mem = in_op.mem_read | in_op.mem_write;
	assign in_fire = in_valid & in_ready;

	assign in_ready = (state == IDLE);
	assign dreq_valid = (state == REQ);
	assign out_valid = (state == DONE);
	assign dreq = req_q;
	assign out_res = res_q;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
		end else begin
			unique case (state)
				IDLE: begin
					if (in_fire) begin
						state <= (is_mem && !wd_misaligned) ? REQ : DONE; // bad accesses skip the bus
					end
				end
				REQ: begin
					if (dreq_ready) state <= WAIT;
				end
				WAIT: begin
					if (dresp_valid) state <= DONE;
				end
				DONE: begin
					if (out_ready) state <= IDLE;
				end
				default: state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire) begin
			op_q <= in_op;
			req_q.addr <= in_op.addr;
			req_q.wdata <= wd_data;
			req_q.strobe <= wd_strobe;
			req_q.write <= in_op.mem_write;
			res_q.dst <= in_op.dst;
			res_q.data <= is_mem ? 64'd0 : in_op.addr; // non-memory ops pass the ALU value
			res_q.misaligned <= is_mem & wd_misaligned;
		end else if (state == WAIT && dresp_valid) begin
			res_q.data <= op_q.mem_read ? ld_data : 64'd0; // stores return zero
		end
	end

endmodule

/* source/mem_top.sv */
`timescale 1ns/1ps

module mem_top #(
	parameter int DEPTH = 256,
	parameter int LATENCY = 2
) (
	input common_pkg::u1 clk,
	input common_pkg::u1 arst_n,

	input common_pkg::u1 in_valid,
	output common_pkg::u1 in_ready,
	input decode_pkg::mem_op_t in_op,

	output common_pkg::u1 out_valid,
	input common_pkg::u1 out_ready,
	output decode_pkg::mem_result_t out_res
);
	import common_pkg::*;

	u1 dreq_valid;
	u1 dreq_ready;
	dbus_req_t dreq;
	u1 dresp_valid;
	dbus_resp_t dresp;

	mem_stage u_stage (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_op(in_op),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res),
		.dreq_valid(dreq_valid),
		.dreq_ready(dreq_ready),
		.dreq(dreq),
		.dresp_valid(dresp_valid),
		.dresp(dresp)
	);

	data_ram #(
		.DEPTH(DEPTH),
		.LATENCY(LATENCY)
	) u_ram (
		.clk(clk),
		.arst_n(arst_n),
		.dreq_valid(dreq_valid),
		.dreq_ready(dreq_ready),
		.dreq(dreq),
		.dresp_valid(dresp_valid),
		.dresp(dresp)
	);

endmodule

/* source/readdata.sv */
`timescale 1ns/1ps

module readdata (
	input common_pkg::u64 _rd,
	output common_pkg::u64 rd,
	input common_pkg::u3 addr,
	input decode_pkg::msize_t msize,
	input common_pkg::u1 mem_unsigned
);
	import common_pkg::*;
	import decode_pkg::*;

	u8 byte_f;
	logic [15:0] half_f;
	logic [31:0] word_f;
	u1 sign_bit;

	// pick each field size from its lane first
	always_comb begin
		byte_f = _rd[7:0];
		unique case (addr)
			3'd0: byte_f = _rd[7:0];
			3'd1: byte_f = _rd[15:8];
			3'd2: byte_f = _rd[23:16];
			3'd3: byte_f = _rd[31:24];
			3'd4: byte_f = _rd[39:32];
			3'd5: byte_f = _rd[47:40];
			3'd6: byte_f = _rd[55:48];
			3'd7: byte_f = _rd[63:56];
			default: byte_f = _rd[7:0];
		endcase
	end

	always_comb begin
		half_f = _rd[15:0];
		unique case (addr[2:1])
			2'd0: half_f = _rd[15:0];
			2'd1: half_f = _rd[31:16];
			2'd2: half_f = _rd[47:32];
			2'd3: half_f = _rd[63:48];
			default: half_f = _rd[15:0];
		endcase
	end

	assign word_f = addr[2] ? _rd[63:32] : _rd[31:0];

	// then extend to 64 bits
	always_comb begin
		sign_bit = 1'b0;
		rd = _rd;
		unique case (msize)
			MSIZE1: begin
				sign_bit = ~mem_unsigned & byte_f[7];
				rd = {{56{sign_bit}}, byte_f};
			end
			MSIZE2: begin
				sign_bit = ~mem_unsigned & half_f[15];
				rd = {{48{sign_bit}}, half_f};
			end
			MSIZE4: begin
				sign_bit = ~mem_unsigned & word_f[31]; // LWU zero-fills
				rd = {{32{sign_bit}}, word_f};
			end
			MSIZE8: begin
				rd = _rd; // no extension needed
			end
			default: begin
				rd = _rd;
			end
		endcase
	end

endmodule

/* source/writedata.sv */
`timescale 1ns/1ps

module writedata (
	input common_pkg::u64 wdata,
	input common_pkg::u3 addr,
	input decode_pkg::msize_t msize,
	output common_pkg::u64 data,
	output common_pkg::u8 strobe,
	output common_pkg::u1 misaligned
);
	import decode_pkg::*;

	// the source is copied into every lane, the strobe picks the live ones
	always_comb begin
		data = wdata;
		strobe = 8'h00;
		misaligned = 1'b0;
		unique case (msize)
			MSIZE1: begin
				data = {8{wdata[7:0]}};
				strobe = 8'b0000_0001 << addr;
			end
			MSIZE2: begin
				data = {4{wdata[15:0]}};
				strobe = 8'b0000_0011 << {addr[2:1], 1'b0};
				misaligned = addr[0];
			end
			MSIZE4: begin
				data = {2{wdata[31:0]}};
				strobe = 8'b0000_1111 << {addr[2], 2'b00};
				misaligned = |addr[1:0];
			end
			MSIZE8: begin
				data = wdata;
				strobe = 8'hff;
				misaligned = |addr;
			end
			default: begin
				strobe = 8'h00;
			end
		endcase
	end

endmodule

/* testbench/mem_top_tb.sv */
`timescale 1ns/1ps

module mem_top_tb;
	import common_pkg::*;
	import decode_pkg::*;

	localparam int DEPTH = 256;
	localparam int LATENCY = 2;
	localparam int TIMEOUT = 200;
	localparam logic [31:0] SEED = 32'h94c7_455d;
	localparam u64 BASE = 64'h200; // 16 doublewords used from here

	logic clk;
	logic arst_n;
	logic in_valid;
	logic in_ready;
	mem_op_t in_op;
	logic out_valid;
	logic out_ready;
	mem_result_t out_res;

	u64 shadow [DEPTH];
	logic [31:0] rng;
	mem_result_t exp_q [$];
	string name_q [$];
	bit skip_q [$]; // data is not defined for misaligned accesses

	mem_top #(
		.DEPTH(DEPTH),
		.LATENCY(LATENCY)
	) u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.in_valid(in_valid),
		.in_ready(in_ready),
		.in_op(in_op),
		.out_valid(out_valid),
		.out_ready(out_ready),
		.out_res(out_res)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("** FAIL **");
		$fatal(1, "simulation stopped on error");
	endtask

	task automatic check_value(input string name, input string what, input u64 exp, input u64 act);
		assert (exp == act)
		else abort_run($sformatf("ERR %s %s expected %h actual %h", name, what, exp, act));
	endtask

	assert property (@(posedge clk) disable iff (!arst_n)
		out_valid && !out_ready |=> out_valid && $stable(out_res))
	else abort_run("out_valid dropped or out_res changed before out_ready");

	assert property (@(posedge clk) disable iff (!arst_n) out_valid |-> !in_ready)
	else abort_run("in_ready high while a result is held");

	// response seen one edge after it rises, LATENCY cycles past acceptance
	assert property (@(posedge clk) disable iff (!arst_n)
		u_dut.dresp_valid |-> $past(u_dut.dreq_valid && u_dut.dreq_ready, LATENCY + 1))
	else abort_run("bus response does not follow an accepted request by the RAM latency");

	assert property (@(posedge clk) disable iff (!arst_n)
		u_dut.dresp_valid |=> !u_dut.dresp_valid)
	else abort_run("bus response longer than one cycle");

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [31:0] next_rand();
		rng = xorshift(rng);
		return rng;
	endfunction

	function automatic u64 rand64();
		u64 v;
		v[63:32] = next_rand();
		v[31:0] = next_rand();
		return v;
	endfunction

	function automatic int size_bytes(input msize_t s);
		case (s)
			MSIZE1: return 1;
			MSIZE2: return 2;
			MSIZE4: return 4;
			default: return 8;
		endcase
	endfunction

	function automatic int dw_index(input u64 a);
		return int'((a >> 3) % u64'(DEPTH));
	endfunction

	function automatic u8 get_byte(input u64 a);
		return shadow[dw_index(a)][8 * int'(a[2:0]) +: 8];
	endfunction

	function automatic void put_byte(input u64 a, input u8 b);
		shadow[dw_index(a)][8 * int'(a[2:0]) +: 8] = b;
	endfunction

	// little-endian memory model, applied at issue since ops complete in order
	function automatic mem_result_t predict(input mem_op_t op);
		mem_result_t r;
		int nb;
		u64 v;
		nb = size_bytes(op.msize);
		v = '0;
		r.dst = op.dst;
		r.data = '0;
		r.misaligned = 1'b0;
		if (!op.mem_read && !op.mem_write) begin
			r.data = op.addr;
		end else if ((op.addr & u64'(nb - 1)) != 64'd0) begin
			r.misaligned = 1'b1;
		end else if (op.mem_write) begin
			for (int i = 0; i < nb; i++)
				put_byte(op.addr + u64'(i), op.wdata[8*i +: 8]);
		end else begin
			for (int i = 0; i < nb; i++)
				v[8*i +: 8] = get_byte(op.addr + u64'(i));
			if (nb < 8 && !op.mem_unsigned && v[8*nb-1])
				v = v | (~64'd0 << (8 * nb)); // sign fill
			r.data = v;
		end
		return r;
	endfunction

	function automatic mem_op_t make_op(input u1 rd, input u1 wr, input u1 uns, input msize_t s,
			input u64 addr, input u64 wdata, input u5 dst);
		mem_op_t op;
		op.addr = addr;
		op.wdata = wdata;
		op.msize = s;
		op.mem_read = rd;
		op.mem_write = wr;
		op.mem_unsigned = uns;
		op.dst = dst;
		return op;
	endfunction

	function automatic u64 pick_addr(input int k, input msize_t s, input bit skew);
		u3 off;
		off = u3'(next_rand()) & ~u3'(size_bytes(s) - 1);
		if (skew)
			off = off | 3'd1; // odd offset, wrong for every size above a byte
		return BASE + u64'(8 * k) + u64'(off);
	endfunction

	function automatic mem_op_t random_op();
		logic [31:0] r;
		msize_t s;
		int k;
		u5 dst;
		r = next_rand();
		k = int'(r[5:2]);
		s = msize_t'(r[7:6]);
		dst = r[13:9];
		case (r[1:0])
			2'd0: return make_op(1'b1, 1'b0, r[8], s, pick_addr(k, s, 1'b0), 64'd0, dst);
			2'd1: return make_op(1'b0, 1'b1, 1'b0, s, pick_addr(k, s, 1'b0), rand64(), dst);
			2'd2: return make_op(1'b0, 1'b0, 1'b0, MSIZE8, rand64(), rand64(), dst);
			default: begin
				if (s == MSIZE1)
					s = MSIZE4;
				return make_op(r[8], ~r[8], 1'b0, s, pick_addr(k, s, 1'b1), rand64(), dst);
			end
		endcase
	endfunction

	// entered and left 1 ns after a rising edge
	task automatic send_op(input mem_op_t op);
		int n;
		n = 0;
		in_valid = 1'b1;
		in_op = op;
		@(negedge clk);
		while (!in_ready) begin
			n++;
			if (n > TIMEOUT)
				abort_run("timeout waiting for in_ready");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic issue_op(input string name, input mem_op_t op);
		exp_q.push_back(predict(op));
		name_q.push_back(name);
		skip_q.push_back((op.mem_read | op.mem_write) &&
			(op.addr & u64'(size_bytes(op.msize) - 1)) != 64'd0);
		send_op(op);
	endtask

	task automatic take_result(input int stall);
		mem_result_t exp;
		string name;
		bit skip;
		int n;
		n = 0;
		@(negedge clk);
		while (!out_valid) begin
			n++;
			if (n > TIMEOUT)
				abort_run("timeout waiting for out_valid");
			@(negedge clk);
		end
		if (exp_q.size() == 0)
			abort_run("result presented with no operation outstanding");
		exp = exp_q.pop_front();
		name = name_q.pop_front();
		skip = skip_q.pop_front();
		check_value(name, "dst", u64'(exp.dst), u64'(out_res.dst));
		check_value(name, "misaligned", u64'(exp.misaligned), u64'(out_res.misaligned));
		if (!skip)
			check_value(name, "data", exp.data, out_res.data);
		repeat (stall) @(posedge clk); // hold the result back
		@(posedge clk);
		#1;
		out_ready = 1'b1;
		@(posedge clk);
		#1;
		out_ready = 1'b0;
	endtask

	task automatic run_op(input string name, input mem_op_t op, input int stall);
		issue_op(name, op);
		take_result(stall);
	endtask

	initial begin
		mem_op_t op;
		msize_t s;
		u64 a;
		int k;
		int nb;
		arst_n = 1'b0;
		in_valid = 1'b0;
		in_op = '0;
		out_ready = 1'b0;
		rng = SEED;
		repeat (10) @(posedge clk);
		#1;
		arst_n = 1'b1;
		@(negedge clk);
		assert (in_ready && !out_valid)
		else abort_run("in_ready low or out_valid high after reset");
		@(posedge clk);
		#1;

		for (int i = 0; i < 16; i++) begin
			op = make_op(1'b0, 1'b1, 1'b0, MSIZE8, BASE + u64'(8 * i), rand64(), u5'(i));
			run_op("fill", op, 0);
		end
		for (int i = 0; i < 16; i++) begin
			for (int si = 0; si < 4; si++) begin
				nb = size_bytes(msize_t'(si));
				for (int off = 0; off < 8; off += nb) begin
					for (int un = 0; un < 2; un++) begin
						a = BASE + u64'(8 * i + off);
						op = make_op(1'b1, 1'b0, u1'(un), msize_t'(si), a, 64'd0, u5'(next_rand()));
						run_op("load_sizes", op, 0);
					end
				end
			end
		end

		for (int i = 0; i < 40; i++) begin
			k = int'(next_rand() & 32'd15);
			s = msize_t'(2'(next_rand() % 32'd3));
			a = pick_addr(k, s, 1'b0);
			op = make_op(1'b0, 1'b1, 1'b0, s, a, rand64(), u5'(next_rand()));
			run_op("narrow_store", op, 1);
			op = make_op(1'b1, 1'b0, 1'b0, MSIZE8, BASE + u64'(8 * k), 64'd0, u5'(next_rand()));
			run_op("narrow_check", op, 0);
		end

		for (int i = 0; i < 12; i++) begin
			k = int'(next_rand() & 32'd15);
			s = msize_t'(2'(32'd1 + next_rand() % 32'd3));
			a = pick_addr(k, s, 1'b1);
			op = make_op(u1'(i % 2), u1'(1 - i % 2), 1'b0, s, a, rand64(), u5'(next_rand()));
			run_op("misaligned", op, 0);
			op = make_op(1'b1, 1'b0, 1'b0, MSIZE8, BASE + u64'(8 * k), 64'd0, u5'(next_rand()));
			run_op("misaligned_check", op, 0);
		end

		for (int i = 0; i < 8; i++) begin
			op = make_op(1'b0, 1'b0, 1'b0, MSIZE8, rand64(), rand64(), u5'(next_rand()));
			run_op("alu_pass", op, 0);
		end

		fork
			begin
				for (int i = 0; i < 60; i++)
					issue_op("mixed", random_op());
			end
			begin
				for (int i = 0; i < 60; i++)
					take_result(int'(next_rand() & 32'd3));
			end
		join
		repeat (5) @(negedge clk);
		assert (!out_valid && exp_q.size() == 0)
		else abort_run("extra result or missing result after the mixed sequence");

		$display("** PASS **");
		$finish;
	end

endmodule
